//--- fir_filter.f
+incdir+rtl
rtl/fir_pkg.sv
rtl/fir_if.sv
rtl/axi_lite_slave.sv
rtl/fir_regs.sv
rtl/fir_mac_array.sv
rtl/fir_sequencer.sv
rtl/fir_top.sv
test/fir_top_properties.sv
test/fir_top_tb.sv

//--- rtl/axi_lite_slave.sv
`include "fir_config.svh"

module axi_lite_slave (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic [`AXI_ADDR_WIDTH-1:0] i_awaddr,
	input  logic i_awvalid,
	output logic o_awready,
	input  fir_pkg::axi_word_t i_wdata,
	input  logic i_wvalid,
	output logic o_wready,
	output logic o_bvalid,
	output logic [1:0] o_bresp,
	input  logic i_bready,
	input  logic [`AXI_ADDR_WIDTH-1:0] i_araddr,
	input  logic i_arvalid,
	output logic o_arready,
	output logic o_rvalid,
	output logic [1:0] o_rresp,
	output fir_pkg::axi_word_t o_rdata,
	input  logic i_rready,
	reg_bus_if.master bus
);
	import fir_pkg::*;

	logic wr_pending;
	logic aw_start;
	logic ar_start;
	reg_addr_t aw_word;
	reg_addr_t ar_word;

	// address and data must both be offered, one write at a time
	assign aw_start = i_awvalid && i_wvalid && !wr_pending;
	// no new read while a response is still waiting
	assign ar_start = !o_arready && i_arvalid && !o_rvalid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			wr_pending <= 1'b0;
		end else begin
			// both ready lines pulse together
			o_awready <= aw_start;
			o_wready <= aw_start;
			// busy until the response is taken
			if (aw_start) begin
				wr_pending <= 1'b1;
			end else if (o_bvalid && i_bready) begin
				wr_pending <= 1'b0;
			end
		end
	end

	// word address of the write
	always_ff @(posedge S_AXI_ACLK) begin
		if (aw_start) begin
			aw_word <= i_awaddr[`AXI_ADDR_WIDTH-1:`ADDR_LSB];
		end
	end

	// register write lands in the ready cycle
	assign bus.wr_en = o_awready && i_awvalid && o_wready && i_wvalid;
	assign bus.wr_addr = aw_word;
	assign bus.wr_data = i_wdata;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_bvalid <= 1'b0;
		end else if (bus.wr_en) begin
			o_bvalid <= 1'b1;
		end else if (i_bready) begin
			o_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			o_arready <= 1'b0;
			o_rvalid <= 1'b0;
		end else begin
			o_arready <= ar_start;
			// data valid the cycle after the address is taken
			if (bus.rd_en) begin
				o_rvalid <= 1'b1;
			end else if (i_rready) begin
				o_rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (ar_start) begin
			ar_word <= i_araddr[`AXI_ADDR_WIDTH-1:`ADDR_LSB];
		end
		// capture the map answer
		if (bus.rd_en) begin
			o_rdata <= bus.rd_data;
		end
	end

	assign bus.rd_en = o_arready && i_arvalid;
	assign bus.rd_addr = ar_word;

	// always OKAY
	assign o_bresp = 2'b00;
	assign o_rresp = 2'b00;

endmodule

//--- rtl/fir_config.svh
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// sample and coefficient widths
`define FIR_DATA_WIDTH 14
`define FIR_COEF_WIDTH 18
// four multipliers, two phases each
`define FIR_DSP_NR 4
`define FIR_TM 2
`define FIR_COEFS_NR 8
// product sums and accumulator
`define FIR_ACC_WIDTH 36
// coefficients are Q1.17 fractions, range -1 up to just below 1
`define FIR_COEF_FRAC 17

// bus geometry
`define AXI_DATA_WIDTH 32
`define AXI_ADDR_WIDTH 16
`define ADDR_LSB 2

// word addresses of the register map
`define REG_ID 0
`define REG_VERSION 1
`define REG_TAPS 2
`define REG_SWITCHES 3
`define REG_COEF_BASE 4

// bits of the switch register
`define SWITCH_FIR_EN 0

`endif

//--- rtl/fir_if.sv
`include "fir_config.svh"

// register requests from the bus slave to the register map
interface reg_bus_if;
	import fir_pkg::*;

	logic wr_en;
	reg_addr_t wr_addr;
	axi_word_t wr_data;
	logic rd_en;
	reg_addr_t rd_addr;
	// combinational answer to rd_addr
	axi_word_t rd_data;

	modport master (output wr_en, output wr_addr, output wr_data,
		output rd_en, output rd_addr, input rd_data);
	modport slave (input wr_en, input wr_addr, input wr_data,
		input rd_addr, output rd_data);
endinterface

// one phase worth of taps between sequencer and multiplier bank
interface mac_if (input logic S_AXI_ACLK);
	import fir_pkg::*;

	sample_t samples [`FIR_DSP_NR];
	coef_t coefs [`FIR_DSP_NR];
	// sum of products, one cycle behind the slices
	acc_t sum;

	modport seq (output samples, output coefs, input sum);
	modport array (input S_AXI_ACLK, input samples, input coefs, output sum);
endinterface

//--- rtl/fir_mac_array.sv
`include "fir_config.svh"

module fir_mac_array (
	mac_if.array mac
);
	import fir_pkg::*;

	acc_t prod_sum;

	// adder tree over all multipliers of one phase
	always_comb begin
		prod_sum = '0;
		for (int k = 0; k < `FIR_DSP_NR; k++) begin
			// widen first so the product keeps all bits
			prod_sum = prod_sum + acc_t'(mac.samples[k]) * acc_t'(mac.coefs[k]);
		end
	end

	// one register stage, new slice every cycle
	always_ff @(posedge mac.S_AXI_ACLK) begin
		mac.sum <= prod_sum;
	end

endmodule

//--- rtl/fir_pkg.sv
`include "fir_config.svh"

package fir_pkg;

	// signed datapath words
	typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
	typedef logic signed [`FIR_COEF_WIDTH-1:0] coef_t;
	typedef logic signed [`FIR_ACC_WIDTH-1:0] acc_t;

	// bus side words
	typedef logic [`AXI_DATA_WIDTH-1:0] axi_word_t;
	// byte offset stripped
	typedef logic [`AXI_ADDR_WIDTH-`ADDR_LSB-1:0] reg_addr_t;

	// sequencer states
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_MAC,
		PH_OUT
	} phase_t;

	// ascii "FIR8", first letter in the top byte
	localparam axi_word_t FIR_ID_WORD = 32'h4649_5238;
	localparam axi_word_t FIR_VERSION_WORD = 32'd1;

endpackage

//--- rtl/fir_regs.sv
`include "fir_config.svh"

module fir_regs (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	reg_bus_if.slave bus,
	output logic o_fir_en,
	output fir_pkg::coef_t o_coefs [`FIR_COEFS_NR]
);
	import fir_pkg::*;

	axi_word_t switches;
	coef_t coefs [`FIR_COEFS_NR];

	// switch word, cleared on reset
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;
		end else if (bus.wr_en && bus.wr_addr == reg_addr_t'(`REG_SWITCHES)) begin
			switches <= bus.wr_data;
		end
	end

	// low 18 bits taken as the signed coefficient
	always_ff @(posedge S_AXI_ACLK) begin
		if (bus.wr_en) begin
			for (int k = 0; k < `FIR_COEFS_NR; k++) begin
				if (bus.wr_addr == reg_addr_t'(`REG_COEF_BASE + k)) begin
					coefs[k] <= coef_t'(bus.wr_data[`FIR_COEF_WIDTH-1:0]);
				end
			end
		end
	end

	// read mux, unmapped words give zero
	always_comb begin
		case (bus.rd_addr)
			reg_addr_t'(`REG_ID): bus.rd_data = FIR_ID_WORD;
			reg_addr_t'(`REG_VERSION): bus.rd_data = FIR_VERSION_WORD;
			reg_addr_t'(`REG_TAPS): bus.rd_data = axi_word_t'(`FIR_COEFS_NR);
			reg_addr_t'(`REG_SWITCHES): bus.rd_data = switches;
			default: bus.rd_data = '0;
		endcase
		// coefficients read back sign extended
		for (int k = 0; k < `FIR_COEFS_NR; k++) begin
			if (bus.rd_addr == reg_addr_t'(`REG_COEF_BASE + k)) begin
				bus.rd_data = {{(`AXI_DATA_WIDTH-`FIR_COEF_WIDTH){coefs[k][`FIR_COEF_WIDTH-1]}},
					coefs[k]};
			end
		end
	end

	assign o_fir_en = switches[`SWITCH_FIR_EN];
	assign o_coefs = coefs;

endmodule

//--- rtl/fir_sequencer.sv
`include "fir_config.svh"

module fir_sequencer (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic i_sample_valid,
	input  fir_pkg::sample_t i_sample,
	input  logic i_fir_en,
	input  fir_pkg::coef_t i_coefs [`FIR_COEFS_NR],
	output logic o_sample_credit,
	output logic o_sample_valid,
	output fir_pkg::sample_t o_sample,
	mac_if.seq mac
);
	import fir_pkg::*;

	localparam int PH_W = $clog2(`FIR_TM);

	phase_t state;
	logic [PH_W-1:0] phase_cnt;
	// source owns a credit
	logic credit_held;
	logic accept;
	// a product sum arrives this cycle
	logic mac_pending;
	// hist[0] is the newest sample
	sample_t hist [`FIR_COEFS_NR];
	acc_t acc;
	acc_t acc_next;

	// samples without a credit are dropped
	assign accept = credit_held && i_sample_valid;
	assign acc_next = mac_pending ? acc + mac.sum : acc;

	// phase p feeds taps p*dsp_nr and up
	always_comb begin
		for (int j = 0; j < `FIR_DSP_NR; j++) begin
			mac.samples[j] = hist[int'(phase_cnt) * `FIR_DSP_NR + j];
			mac.coefs[j] = i_coefs[int'(phase_cnt) * `FIR_DSP_NR + j];
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= PH_IDLE;
			phase_cnt <= '0;
			credit_held <= 1'b0;
			o_sample_credit <= 1'b0;
			o_sample_valid <= 1'b0;
			mac_pending <= 1'b0;
		end else begin
			o_sample_credit <= 1'b0;
			o_sample_valid <= 1'b0;
			// bank answers one cycle after each issued phase
			mac_pending <= (state == PH_MAC);
			case (state)
				PH_IDLE: begin
					// first credit after reset
					if (!credit_held) begin
						o_sample_credit <= 1'b1;
						credit_held <= 1'b1;
					end else if (accept && i_fir_en) begin
						credit_held <= 1'b0;
						phase_cnt <= '0;
						state <= PH_MAC;
					end else if (accept) begin
						// bypass, credit comes straight back
						o_sample_valid <= 1'b1;
						o_sample_credit <= 1'b1;
					end
				end
				PH_MAC: begin
					phase_cnt <= phase_cnt + 1'b1;
					if (phase_cnt == PH_W'(`FIR_TM - 1)) begin
						state <= PH_OUT;
					end
				end
				PH_OUT: begin
					// last sum is in, result and credit together
					o_sample_valid <= 1'b1;
					o_sample_credit <= 1'b1;
					credit_held <= 1'b1;
					state <= PH_IDLE;
				end
				default: state <= PH_IDLE;
			endcase
		end
	end

	// delay line, emptied while the filter is off
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || !i_fir_en) begin
			for (int k = 0; k < `FIR_COEFS_NR; k++) begin
				hist[k] <= '0;
			end
		end else if (accept) begin
			hist[0] <= i_sample;
			for (int k = 1; k < `FIR_COEFS_NR; k++) begin
				hist[k] <= hist[k-1];
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (accept) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
		if (accept && !i_fir_en) begin
			o_sample <= i_sample;
		end else if (state == PH_OUT) begin
			// drop fraction bits, keep the low 14
			o_sample <= sample_t'(acc_next >>> `FIR_COEF_FRAC);
		end
	end

endmodule

//--- rtl/fir_top.sv
`include "fir_config.svh"

module fir_top (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic [`AXI_ADDR_WIDTH-1:0] i_awaddr,
	input  logic i_awvalid,
	output logic o_awready,
	input  fir_pkg::axi_word_t i_wdata,
	input  logic i_wvalid,
	output logic o_wready,
	output logic o_bvalid,
	output logic [1:0] o_bresp,
	input  logic i_bready,
	input  logic [`AXI_ADDR_WIDTH-1:0] i_araddr,
	input  logic i_arvalid,
	output logic o_arready,
	output logic o_rvalid,
	output logic [1:0] o_rresp,
	output fir_pkg::axi_word_t o_rdata,
	input  logic i_rready,
	input  logic i_sample_valid,
	input  fir_pkg::sample_t i_sample,
	output logic o_sample_credit,
	output logic o_sample_valid,
	output fir_pkg::sample_t o_sample
);
	import fir_pkg::*;

	logic fir_en;
	coef_t coefs [`FIR_COEFS_NR];

	reg_bus_if u_reg_bus ();
	mac_if u_mac_if (.S_AXI_ACLK(S_AXI_ACLK));

	// bus side
	axi_lite_slave u_axi_lite_slave (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_awaddr(i_awaddr),
		.i_awvalid(i_awvalid),
		.o_awready(o_awready),
		.i_wdata(i_wdata),
		.i_wvalid(i_wvalid),
		.o_wready(o_wready),
		.o_bvalid(o_bvalid),
		.o_bresp(o_bresp),
		.i_bready(i_bready),
		.i_araddr(i_araddr),
		.i_arvalid(i_arvalid),
		.o_arready(o_arready),
		.o_rvalid(o_rvalid),
		.o_rresp(o_rresp),
		.o_rdata(o_rdata),
		.i_rready(i_rready),
		.bus(u_reg_bus.master)
	);

	fir_regs u_fir_regs (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.bus(u_reg_bus.slave),
		.o_fir_en(fir_en),
		.o_coefs(coefs)
	);

	// filter core
	fir_sequencer u_fir_sequencer (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.i_sample_valid(i_sample_valid),
		.i_sample(i_sample),
		.i_fir_en(fir_en),
		.i_coefs(coefs),
		.o_sample_credit(o_sample_credit),
		.o_sample_valid(o_sample_valid),
		.o_sample(o_sample),
		.mac(u_mac_if.seq)
	);

	fir_mac_array u_fir_mac_array (
		.mac(u_mac_if.array)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench and the design from the file list
verilator --binary --timing --assert -Wno-fatal --top-module fir_top_tb \
	-f fir_filter.f -Mdir obj_dir || exit 1
# run once and keep the output in memory
out=$(./obj_dir/Vfir_top_tb +verilator+error+limit+100)
echo "$out"
# the pass line alone decides the result
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/fir_cases.txt
# op name arg expected, all values hex
# w and r take a word address, s and b a 14-bit sample, r s b carry the expected value
r id_reset 0 46495238
r version 1 1
r taps 2 8
r switches_reset 3 0
w coef0_neg 4 3ffff
r coef0_readback 4 ffffffff
w coef1_mask 5 fff20000
r coef1_readback 5 fffe0000
w id_write 0 12345678
r id_kept 0 46495238
w unmapped_write c 55
r unmapped_read c 0
w coef0 4 20000
w coef1 5 20000
w coef2 6 20000
w coef3 7 20000
w coef4 8 20000
w coef5 9 10000
w coef6 a 20000
w coef7 b 20000
w enable 3 1
s impulse 3e8 3c18
s tap1 0 3c18
s tap2 0 3c18
s tap3 0 3c18
s tap4 0 3c18
s tap5 0 1f4
s tap6 0 3c18
s tap7 0 3c18
s flushed 0 0
s history 200 3e00
w disable 3 0
b bypass_pos 123 123
b bypass_neg 3f00 3f00
w enable_again 3 1
s restart 100 3f00
w coef2_mix 6 0c000
w coef7_mix b 3f000

//--- test/fir_top_properties.sv
module fir_top_properties (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic i_bvalid,
	input logic i_bready,
	input logic i_rvalid,
	input logic i_rready,
	input logic i_sample_valid,
	input logic i_sample_credit,
	input logic i_out_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// credits owned by the source
	int credits;
	// an accepted sample has not come out yet
	logic in_flight;
	// failed assertions so far
	int fail_count = 0;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			credits <= 0;
			in_flight <= 1'b0;
		end else begin
			credits <= credits + (i_sample_credit ? 1 : 0)
				- ((i_sample_valid && credits > 0) ? 1 : 0);
			if (i_sample_valid && credits > 0) begin
				in_flight <= 1'b1;
			end else if (i_out_valid) begin
				in_flight <= 1'b0;
			end
		end
	end

	// responses stay up until taken
	bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_bvalid && !i_bready |=> i_bvalid)
		else begin
			$error("BVALID dropped before BREADY");
			fail_count++;
		end

	rvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_rvalid && !i_rready |=> i_rvalid)
		else begin
			$error("RVALID dropped before RREADY");
			fail_count++;
		end

	// no second credit while the source still holds one
	one_credit: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_sample_credit |-> credits == 0)
		else begin
			$error("credit granted while one is still held");
			fail_count++;
		end

	// one result per accepted sample
	one_result: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_out_valid |-> in_flight)
		else begin
			$error("output valid without an accepted sample");
			fail_count++;
		end

endmodule

bind fir_top fir_top_properties u_fir_top_properties (
	.S_AXI_ACLK(S_AXI_ACLK),
	.S_AXI_ARESETN(S_AXI_ARESETN),
	.i_bvalid(o_bvalid),
	.i_bready(i_bready),
	.i_rvalid(o_rvalid),
	.i_rready(i_rready),
	.i_sample_valid(i_sample_valid),
	.i_sample_credit(o_sample_credit),
	.i_out_valid(o_sample_valid)
);

//--- test/fir_top_tb.sv
`include "fir_config.svh"

module fir_top_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import fir_pkg::*;

	localparam int N_RANDOM = 24;
	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [`AXI_ADDR_WIDTH-1:0] i_awaddr;
	logic i_awvalid;
	logic o_awready;
	axi_word_t i_wdata;
	logic i_wvalid;
	logic o_wready;
	logic o_bvalid;
	logic [1:0] o_bresp;
	logic i_bready;
	logic [`AXI_ADDR_WIDTH-1:0] i_araddr;
	logic i_arvalid;
	logic o_arready;
	logic o_rvalid;
	logic [1:0] o_rresp;
	axi_word_t o_rdata;
	logic i_rready;
	logic i_sample_valid;
	sample_t i_sample;
	logic o_sample_credit;
	logic o_sample_valid;
	sample_t o_sample;

	// case table from the data file
	logic [7:0] case_op [$];
	string case_name [$];
	axi_word_t case_arg [$];
	axi_word_t case_exp [$];

	int cycles = 0;
	int cycle_limit = 0;
	int credits_got = 0;
	int samples_sent = 0;
	logic [31:0] rng_state;
	// reference model, hist_m[0] newest
	longint coef_m [`FIR_COEFS_NR];
	longint hist_m [`FIR_COEFS_NR];

	fir_top u_fir_top (.*);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// credit pulses counted on the edge after they show
	always @(posedge S_AXI_ACLK) begin
		if (o_sample_credit) begin
			credits_got <= credits_got + 1;
		end
	end

	always @(posedge S_AXI_ACLK) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// sum of coef k times the sample k steps back, Q1.17 scaling
	function automatic sample_t predict_output();
		longint sum;
		sum = 0;
		for (int k = 0; k < `FIR_COEFS_NR; k++) begin
			sum += coef_m[k] * hist_m[k];
		end
		return sample_t'(sum >>> `FIR_COEF_FRAC);
	endfunction

	task automatic push_history(input sample_t s);
		for (int k = `FIR_COEFS_NR - 1; k > 0; k--) begin
			hist_m[k] = hist_m[k-1];
		end
		hist_m[0] = longint'(s);
	endtask

	// coefficient words and the enable bit as seen by the model
	task automatic mirror_write(input int word, input axi_word_t data);
		if (word >= `REG_COEF_BASE && word < `REG_COEF_BASE + `FIR_COEFS_NR) begin
			coef_m[word - `REG_COEF_BASE] = longint'(coef_t'(data[`FIR_COEF_WIDTH-1:0]));
		end
		// filter off empties the history
		if (word == `REG_SWITCHES && !data[`SWITCH_FIR_EN]) begin
			hist_m = '{default: 0};
		end
	endtask

	task automatic check_word(input string name, input axi_word_t exp, input axi_word_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("tests failed");
			$fatal(1, "register mismatch");
		end
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("tests failed");
			$fatal(1, "sample mismatch");
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			$display("error %s expected %h actual %h", name, exp, act);
			$display("tests failed");
			$fatal(1, "response mismatch");
		end
	endtask

	task automatic axi_write(input string name, input reg_addr_t word, input axi_word_t data);
		i_awaddr = {word, {`ADDR_LSB{1'b0}}};
		i_wdata = data;
		i_awvalid = 1'b1;
		i_wvalid = 1'b1;
		// both ready lines pulse, write lands on the next edge
		do begin
			@(negedge S_AXI_ACLK);
		end while (!(o_awready && o_wready));
		@(negedge S_AXI_ACLK);
		i_awvalid = 1'b0;
		i_wvalid = 1'b0;
		while (!o_bvalid) begin
			@(negedge S_AXI_ACLK);
		end
		// response kept waiting one cycle before it is taken
		@(negedge S_AXI_ACLK);
		check_resp({name, "_bresp"}, RESP_OKAY, o_bresp);
		i_bready = 1'b1;
		@(negedge S_AXI_ACLK);
		i_bready = 1'b0;
	endtask

	task automatic axi_read(input string name, input reg_addr_t word, output axi_word_t data);
		i_araddr = {word, {`ADDR_LSB{1'b0}}};
		i_arvalid = 1'b1;
		do begin
			@(negedge S_AXI_ACLK);
		end while (!o_arready);
		@(negedge S_AXI_ACLK);
		i_arvalid = 1'b0;
		while (!o_rvalid) begin
			@(negedge S_AXI_ACLK);
		end
		// data has to stay put while RREADY is low
		@(negedge S_AXI_ACLK);
		check_resp({name, "_rresp"}, RESP_OKAY, o_rresp);
		data = o_rdata;
		i_rready = 1'b1;
		@(negedge S_AXI_ACLK);
		i_rready = 1'b0;
	endtask

	// spends one credit, then waits for the result
	task automatic send_sample(input sample_t s, output sample_t result);
		while (credits_got == samples_sent) begin
			@(negedge S_AXI_ACLK);
		end
		i_sample = s;
		i_sample_valid = 1'b1;
		samples_sent++;
		@(negedge S_AXI_ACLK);
		i_sample_valid = 1'b0;
		while (!o_sample_valid) begin
			@(negedge S_AXI_ACLK);
		end
		result = o_sample;
	endtask

	initial begin
		int fd;
		logic [7:0] op;
		logic [8*24-1:0] name;
		logic [8*100-1:0] skip_line;
		axi_word_t arg;
		axi_word_t exp_val;
		axi_word_t word;
		sample_t smp;
		sample_t got;
		sample_t expected;

		S_AXI_ARESETN = 1'b0;
		i_awaddr = '0;
		i_awvalid = 1'b0;
		i_wdata = '0;
		i_wvalid = 1'b0;
		i_bready = 1'b0;
		i_araddr = '0;
		i_arvalid = 1'b0;
		i_rready = 1'b0;
		i_sample_valid = 1'b0;
		i_sample = '0;
		hist_m = '{default: 0};
		coef_m = '{default: 0};

		fd = $fopen("test/fir_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/fir_cases.txt");
			$display("tests failed");
			$fatal(1, "missing case file");
		end
		while ($fscanf(fd, "%s", op) == 1) begin
			if (op == "#") begin
				void'($fgets(skip_line, fd));
			end else begin
				void'($fscanf(fd, "%s %h %h", name, arg, exp_val));
				case_op.push_back(op);
				case_name.push_back($sformatf("%0s", name));
				case_arg.push_back(arg);
				case_exp.push_back(exp_val);
			end
		end
		$fclose(fd);
		cycle_limit = 20 * case_op.size() + 40 * N_RANDOM;

		repeat (2) @(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		for (int i = 0; i < case_op.size(); i++) begin
			case (case_op[i])
				"w": begin
					axi_write(case_name[i], reg_addr_t'(case_arg[i]), case_exp[i]);
					mirror_write(int'(case_arg[i]), case_exp[i]);
				end
				"r": begin
					axi_read(case_name[i], reg_addr_t'(case_arg[i]), word);
					check_word(case_name[i], case_exp[i], word);
				end
				"s": begin
					smp = sample_t'(case_arg[i]);
					push_history(smp);
					send_sample(smp, got);
					check_sample(case_name[i], sample_t'(case_exp[i]), got);
					check_sample({case_name[i], "_model"}, predict_output(), got);
				end
				"b": begin
					send_sample(sample_t'(case_arg[i]), got);
					check_sample(case_name[i], sample_t'(case_exp[i]), got);
				end
				default: begin
					$display("unknown operation in the case file at entry %0d", i);
					$display("tests failed");
					$fatal(1, "bad case file");
				end
			endcase
		end

		// extra stream on the last coefficient set
		rng_state = 32'd65787;
		for (int n = 0; n < N_RANDOM; n++) begin
			rng_state = xorshift32(rng_state);
			smp = sample_t'(rng_state[`FIR_DATA_WIDTH-1:0]);
			push_history(smp);
			expected = predict_output();
			send_sample(smp, got);
			check_sample($sformatf("random_%0d", n), expected, got);
		end

		repeat (2) @(negedge S_AXI_ACLK);
		if (u_fir_top.u_fir_top_properties.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("%0d assertion failures", u_fir_top.u_fir_top_properties.fail_count);
			$display("tests failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule
